// ==== logic/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// processor side word address
`define DC_ADDR_W     30

// memory side block address, word address without the word offset
`define DC_MEM_ADDR_W 28

// data widths
`define DC_WORD_W     32
`define DC_BLOCK_W    128

// tag is the word address above set and offset bits
`define DC_TAG_W      26

// geometry
`define DC_SETS       4
`define DC_WAYS       2
`define DC_WORDS      4

`endif

// ==== logic/dcache_pkg.sv ====
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    // controller states
    typedef enum logic [1:0] {
        REQUEST  = 2'b00,
        READMEM  = 2'b01,
        WRITEMEM = 2'b10
    } dc_state_t;

    // one processor word
    typedef logic [`DC_WORD_W-1:0] word_t;

    // a full line, word 0 in the low bits
    typedef logic [`DC_BLOCK_W-1:0] block_t;

    typedef logic [`DC_TAG_W-1:0] tag_t;

    // set number and word offset inside a block
    typedef logic [$clog2(`DC_SETS)-1:0] set_idx_t;
    typedef logic [$clog2(`DC_WORDS)-1:0] word_off_t;

    // block address as seen by the memory
    typedef logic [`DC_MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// ==== logic/line_access_if.sv ====
`default_nettype none

interface line_access_if import dcache_pkg::*; ();

    // controller to line store
    logic      refill;
    logic      merge_store;
    block_t    refill_block;

    // line store to controller
    logic      hit;
    word_t     rd_word;
    logic      victim_dirty;
    mem_addr_t victim_addr;
    block_t    victim_block;

    modport ctrl (
        output refill,
        output merge_store,
        output refill_block,
        input  hit,
        input  rd_word,
        input  victim_dirty,
        input  victim_addr,
        input  victim_block
    );

    modport store (
        input  refill,
        input  merge_store,
        input  refill_block,
        output hit,
        output rd_word,
        output victim_dirty,
        output victim_addr,
        output victim_block
    );

endinterface

`default_nettype wire

// ==== logic/line_store.sv ====
`default_nettype none

`include "dcache_settings.svh"

module line_store import dcache_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  proc_reset,
    input  wire logic                  proc_read,
    input  wire logic                  proc_write,
    input  wire logic [`DC_ADDR_W-1:0] proc_addr,
    input  wire word_t                 proc_wdata,
    line_access_if.store               acc
);

    // line storage, way 0 holds the most recently refilled block
    tag_t   tag_q   [`DC_SETS][`DC_WAYS];
    block_t data_q  [`DC_SETS][`DC_WAYS];
    logic   valid_q [`DC_SETS][`DC_WAYS];
    logic   dirty_q [`DC_SETS][`DC_WAYS];

    // address fields
    word_off_t word_off;
    set_idx_t  set_idx;
    tag_t      addr_tag;

    logic [`DC_WAYS-1:0] hit_way;
    logic                way_sel;
    logic                access;
    word_t               hit_word;
    word_t               fill_word;
    block_t              fill_block;
    logic                fill_dirty;
    logic                wr_change;

    assign word_off = proc_addr[1:0];
    assign set_idx  = proc_addr[3:2];
    assign addr_tag = proc_addr[`DC_ADDR_W-1:4];
    assign access   = proc_read | proc_write;

    // tag compare in both ways of the set
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == addr_tag);
        end
    end

    // way 0 wins, only one way can match anyway
    assign way_sel = ~hit_way[0];
    assign acc.hit = access & (|hit_way);

    assign hit_word  = data_q[set_idx][way_sel][word_off*`DC_WORD_W +: `DC_WORD_W];
    assign fill_word = acc.refill_block[word_off*`DC_WORD_W +: `DC_WORD_W];

    // during a refill the word comes straight from memory
    assign acc.rd_word = acc.refill ? fill_word : hit_word;

    // way 1 is always the victim
    assign acc.victim_dirty = valid_q[set_idx][1] & dirty_q[set_idx][1];
    assign acc.victim_addr  = {tag_q[set_idx][1], set_idx};
    assign acc.victim_block = data_q[set_idx][1];

    // refill block with the store word merged in on a write miss
    always_comb begin
        fill_block = acc.refill_block;
        for (int k = 0; k < `DC_WORDS; k++) begin
            if (acc.merge_store && (word_off == k)) begin
                fill_block[k*`DC_WORD_W +: `DC_WORD_W] = proc_wdata;
            end
        end
    end

    // a merged store that changes the fetched word makes the new line dirty,
    // the write hit in the following cycle then sees an equal word
    assign fill_dirty = acc.merge_store && (fill_word != proc_wdata);

    // silent stores leave the line clean
    assign wr_change = proc_write && acc.hit && !acc.refill && (hit_word != proc_wdata);

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                end
            end
        end else if (acc.refill) begin
            // shift way 0 down, new block enters way 0
            valid_q[set_idx][1] <= valid_q[set_idx][0];
            dirty_q[set_idx][1] <= dirty_q[set_idx][0];
            valid_q[set_idx][0] <= 1'b1;
            dirty_q[set_idx][0] <= fill_dirty;
        end else if (wr_change) begin
            dirty_q[set_idx][way_sel] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.refill) begin
            tag_q[set_idx][1]  <= tag_q[set_idx][0];
            data_q[set_idx][1] <= data_q[set_idx][0];
            tag_q[set_idx][0]  <= addr_tag;
            data_q[set_idx][0] <= fill_block;
        end else if (wr_change) begin
            data_q[set_idx][way_sel][word_off*`DC_WORD_W +: `DC_WORD_W] <= proc_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_ctrl.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  proc_reset,
    input  wire logic                  proc_read,
    input  wire logic                  proc_write,
    input  wire logic [`DC_ADDR_W-1:0] proc_addr,
    input  wire block_t                mem_rdata,
    input  wire logic                  mem_ready,
    line_access_if.ctrl                acc,
    output logic                       proc_stall,
    output word_t                      proc_rdata,
    output logic                       mem_read,
    output logic                       mem_write,
    output mem_addr_t                  mem_addr,
    output block_t                     mem_wdata
);

    dc_state_t state_q;
    dc_state_t state_d;

    logic      req;
    mem_addr_t proc_block_addr;

    assign req             = proc_read | proc_write;
    assign proc_block_addr = proc_addr[`DC_ADDR_W-1:`DC_ADDR_W-`DC_MEM_ADDR_W];

    // memory data goes to the line store as is, merging happens there
    assign acc.refill_block = mem_rdata;

    always_comb begin
        state_d         = state_q;
        proc_stall      = 1'b0;
        proc_rdata      = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_addr        = '0;
        mem_wdata       = '0;
        acc.refill      = 1'b0;
        acc.merge_store = 1'b0;

        case (state_q)
            REQUEST: begin
                if (req && acc.hit) begin
                    // hit, reads return now, writes land on the next edge
                    if (proc_read) begin
                        proc_rdata = acc.rd_word;
                    end
                end else if (req) begin
                    proc_stall = 1'b1;
                    if (acc.victim_dirty) begin
                        state_d = WRITEMEM;
                    end else begin
                        state_d = READMEM;
                    end
                end
            end

            WRITEMEM: begin
                // push the dirty victim out first
                proc_stall = 1'b1;
                mem_write  = 1'b1;
                mem_addr   = acc.victim_addr;
                mem_wdata  = acc.victim_block;
                if (mem_ready) begin
                    state_d = READMEM;
                end
            end

            READMEM: begin
                proc_stall = 1'b1;
                mem_read   = 1'b1;
                mem_addr   = proc_block_addr;
                if (mem_ready) begin
                    acc.refill      = 1'b1;
                    acc.merge_store = proc_write;
                    state_d         = REQUEST;
                    // read finishes with the fetched word,
                    // a write stalls one more cycle and completes as a hit
                    if (proc_read) begin
                        proc_stall = 1'b0;
                        proc_rdata = acc.rd_word;
                    end
                end
            end

            default: begin
                state_d = REQUEST;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q <= REQUEST;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  proc_reset,
    input  wire logic                  proc_read,
    input  wire logic                  proc_write,
    input  wire logic [`DC_ADDR_W-1:0] proc_addr,
    input  wire word_t                 proc_wdata,
    output logic                       proc_stall,
    output word_t                      proc_rdata,
    input  wire block_t                mem_rdata,
    input  wire logic                  mem_ready,
    output logic                       mem_read,
    output logic                       mem_write,
    output mem_addr_t                  mem_addr,
    output block_t                     mem_wdata
);

    // refill control one way, lookup results the other
    line_access_if acc_if ();

    dcache_ctrl ctrl_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .acc        (acc_if.ctrl),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    // tags, flags and data for all sets
    line_store store_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .acc        (acc_if.store)
    );

endmodule

`default_nettype wire

// ==== verif/mem_model.sv ====
`default_nettype none

module mem_model import dcache_pkg::*; (
    input  wire logic      clk,
    input  wire logic      proc_reset,
    input  wire logic      mem_read,
    input  wire logic      mem_write,
    input  wire mem_addr_t mem_addr,
    input  wire block_t    mem_wdata,
    output block_t         mem_rdata,
    output logic           mem_ready,
    output int             wb_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_WRITES = 64;

    // blocks written back so far, every other block still holds the fill pattern
    mem_addr_t wr_addr [MAX_WRITES];
    block_t    wr_data [MAX_WRITES];
    int        wr_used = 0;

    integer seed = 32'h0135_24ff;
    logic   pending;
    int     wait_left;

    // fill pattern is the word address xor a constant
    function automatic block_t read_block(input mem_addr_t addr);
        block_t blk;
        for (int k = 0; k < 4; k++) begin
            blk[k*32 +: 32] = {2'b00, addr, word_off_t'(k)} ^ 32'hA5A5_0000;
        end
        for (int j = 0; j < wr_used; j++) begin
            if (wr_addr[j] == addr) begin
                blk = wr_data[j];
            end
        end
        return blk;
    endfunction

    task automatic store_block(input mem_addr_t addr, input block_t data);
        int slot;
        slot = wr_used;
        for (int j = 0; j < wr_used; j++) begin
            if (wr_addr[j] == addr) begin
                slot = j;
            end
        end
        wr_addr[slot] = addr;
        wr_data[slot] = data;
        if (slot == wr_used) begin
            wr_used++;
        end
    endtask

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        wb_count  = 0;
        pending   = 1'b0;
        wait_left = 0;
    end

    always @(posedge clk) begin
        if (proc_reset) begin
            mem_ready <= 1'b0;
            pending   <= 1'b0;
            wb_count  <= 0;
        end else if (mem_ready) begin
            // transfer completes in the ready cycle
            mem_ready <= 1'b0;
            pending   <= 1'b0;
            if (mem_write) begin
                store_block(mem_addr, mem_wdata);
                wb_count <= wb_count + 1;
            end
        end else if (mem_read || mem_write) begin
            if (!pending) begin
                // 1 to 4 wait cycles before ready
                pending   <= 1'b1;
                wait_left <= $unsigned($random(seed)) % 4;
            end else if (wait_left == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= read_block(mem_addr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/dcache_tb.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb import dcache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLES_PER_TEST = 12;
    localparam int RESET_CYCLES    = 16;

    logic                  clk = 1'b0;
    logic                  proc_reset;
    logic                  proc_read;
    logic                  proc_write;
    logic [`DC_ADDR_W-1:0] proc_addr;
    word_t                 proc_wdata;
    logic                  proc_stall;
    word_t                 proc_rdata;
    block_t                mem_rdata;
    logic                  mem_ready;
    logic                  mem_read;
    logic                  mem_write;
    mem_addr_t             mem_addr;
    block_t                mem_wdata;
    int                    wb_count;

    // test table from the stim file
    string       t_name  [$];
    string       t_op    [$];
    logic [31:0] t_addr  [$];
    logic [31:0] t_wdata [$];
    logic [31:0] t_rdata [$];
    int          t_wb    [$];
    int          t_fetch [$];

    int mismatches  = 0;
    int passed      = 0;
    int failed      = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    always #10 clk = ~clk;

    dcache_top dut_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    mem_model mem_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .wb_count   (wb_count)
    );

    // run length guard, limit set once the test count is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout, the accesses did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic tally_test(input string name);
        if (mismatches == 0) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: %0d mismatches", name, mismatches);
        end
        mismatches = 0;
    endtask

    task automatic read_stim(output bit ok);
        int          fd;
        int          fields;
        string       line;
        string       name;
        string       op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        int          wb;
        int          fetch;
        ok = 1'b1;
        fd = $fopen("verif/dcache_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/dcache_stim.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                fields = $fgets(line, fd);
                // skip blank lines and comments
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    fields = $sscanf(line, "%s %s %h %h %h %d %d",
                                     name, op, addr, wdata, rdata, wb, fetch);
                    if (fields != 7 || (op != "R" && op != "W")) begin
                        $display("malformed stimulus line: %s", line);
                        ok = 1'b0;
                    end else begin
                        t_name.push_back(name);
                        t_op.push_back(op);
                        t_addr.push_back(addr);
                        t_wdata.push_back(wdata);
                        t_rdata.push_back(rdata);
                        t_wb.push_back(wb);
                        t_fetch.push_back(fetch);
                    end
                end
            end
            $fclose(fd);
            if (t_name.size() == 0) begin
                $display("the stimulus file holds no tests");
                ok = 1'b0;
            end
        end
    endtask

    task automatic run_access(input int i);
        logic  fetched;
        word_t rdata;
        fetched = 1'b0;
        @(posedge clk);
        proc_read  <= (t_op[i] == "R");
        proc_write <= (t_op[i] == "W");
        proc_addr  <= t_addr[i][`DC_ADDR_W-1:0];
        proc_wdata <= t_wdata[i];
        // request held until the stall drops
        do begin
            @(negedge clk);
            fetched = fetched | mem_read;
        end while (proc_stall);
        rdata = proc_rdata;
        if (t_op[i] == "R") begin
            check_value({t_name[i], " rdata"}, t_rdata[i], rdata);
        end
        check_value({t_name[i], " fetch"}, t_fetch[i], fetched);
        check_value({t_name[i], " writebacks"}, t_wb[i], wb_count);
        tally_test(t_name[i]);
    endtask

    initial begin
        bit stim_ok;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        read_stim(stim_ok);
        if (!stim_ok) begin
            $display("the stimulus could not be read, no test was run");
            $display("Something failed");
        end else begin
            cycle_limit = RESET_CYCLES + 2 + t_name.size() * CYCLES_PER_TEST;
            repeat (RESET_CYCLES) @(posedge clk);
            proc_reset <= 1'b0;
            // idle cache after reset
            @(negedge clk);
            check_value("reset_idle proc_stall", 0, proc_stall);
            check_value("reset_idle mem_read", 0, mem_read);
            check_value("reset_idle mem_write", 0, mem_write);
            tally_test("reset_idle");
            foreach (t_name[i]) begin
                run_access(i);
            end
            @(posedge clk);
            proc_read  <= 1'b0;
            proc_write <= 1'b0;
            $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
            if (failed == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dcache_stim.txt ====
# name op(R/W) word_addr(hex) wdata(hex) expected_rdata(hex) writebacks_so_far fetch(0/1)
# expected_rdata is ignored for writes, fetch is 1 when a memory read is seen
rd_miss_a R 00000005 00000000 a5a50005 0 1
rd_hit_a R 00000005 00000000 a5a50005 0 0
rd_hit_a2 R 00000006 00000000 a5a50006 0 0
wr_hit_a W 00000006 12345678 00000000 0 0
rd_back_a R 00000006 00000000 12345678 0 0
rd_keep_a R 00000007 00000000 a5a50007 0 0
wr_miss_b W 00000015 cafef00d 00000000 0 1
rd_back_b R 00000015 00000000 cafef00d 0 0
rd_keep_b R 00000014 00000000 a5a50014 0 0
rd_miss_c R 00000024 00000000 a5a50024 1 1
rd_hit_b R 00000015 00000000 cafef00d 1 0
rd_refetch_a R 00000006 00000000 12345678 2 1
rd_hit_c R 00000024 00000000 a5a50024 2 0
rd_miss_d R 00000009 00000000 a5a50009 2 1
wr_silent_d W 00000009 a5a50009 00000000 2 0
rd_miss_e R 00000019 00000000 a5a50019 2 1
rd_miss_f R 00000029 00000000 a5a50029 2 1
wr_miss_silent_g W 0000000c a5a5000c 00000000 2 1
rd_miss_h R 0000001c 00000000 a5a5001c 2 1
rd_miss_i R 0000002c 00000000 a5a5002c 2 1
rd_miss_hi R 3ffffff0 00000000 9a5afff0 2 1
wr_hit_hi W 3ffffff3 0badbeef 00000000 2 0
rd_miss_lo R 00000000 00000000 a5a50000 2 1
rd_miss_mid R 10000001 00000000 b5a50001 3 1
rd_refetch_hi R 3ffffff3 00000000 0badbeef 3 1

// ==== tb.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/line_access_if.sv
logic/line_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/mem_model.sv
verif/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - logic

sources:
  - logic/dcache_pkg.sv
  - logic/line_access_if.sv
  - logic/line_store.sv
  - logic/dcache_ctrl.sv
  - logic/dcache_top.sv
  - target: simulation
    files:
      - verif/mem_model.sv
      - verif/dcache_tb.sv
